//--- ahb_mem_config.svh
/*
 * Build-time constants for the dual-port AHB-Lite memory
 * Bus width, array size, IRQ line count and special addresses
 */

`ifndef AHB_MEM_CONFIG_SVH
`define AHB_MEM_CONFIG_SVH

// --------------------
// Bus and array geometry
// --------------------
`define AHB_WIDTH       32
`define MEM_POWER_SIZE  12

// Interrupt lines driven from the IRQ register
`define IRQ_LINES_NUM   16

// --------------------
// Special addresses
// --------------------
`define IRQ_ADDR        32'hF000_0100
`define ERR_PTR_ADDR    32'hF000_0200
// Fixed error address, also the error pointer value after reset
`define MEM_ERR_ADDR    32'hFFFF_F100

`endif

//--- ahb_mem_pkg.sv
/*
 * Shared types for the dual-port AHB-Lite memory
 * Transfer enums, port request and response structs, byte-enable helper
 */

`include "ahb_mem_config.svh"

package ahb_mem_pkg;

    typedef logic [`AHB_WIDTH-1:0] word_t;
    typedef logic [3:0]            be_t;

    // --------------------
    // AHB-Lite encodings
    // --------------------
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    // --------------------
    // Port payloads
    // --------------------
    typedef struct packed {
        htrans_e htrans;
        hsize_e  hsize;
        word_t   haddr;
    } imem_req_t;

    typedef struct packed {
        htrans_e htrans;
        hsize_e  hsize;
        word_t   haddr;
        logic    hwrite;
    } dmem_req_t;

    typedef struct packed {
        logic   hready;
        hresp_e hresp;
        word_t  hrdata;
    } ahb_rsp_t;

    // Byte lanes touched by a transfer of the given size
    function automatic be_t be_form(hsize_e size, logic [1:0] offset);
        be_t be;
        case (size)
            BYTE:    be = 4'b0001 << offset;
            HALF:    be = 4'b0011 << offset;
            WORD:    be = 4'b1111;
            default: be = 4'b0000;
        endcase
        return be;
    endfunction

endpackage

//--- ahb_port_ctrl.sv
/*
 * AHB-Lite port pipeline tracker
 * Latches the address phase and forms the data-phase response
 */

`timescale 1ns/1ps

module ahb_port_ctrl
    import ahb_mem_pkg::*;
#(
    parameter type req_t = imem_req_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  req_t     req,
    input  logic     addr_err,
    input  word_t    rdata,
    output ahb_rsp_t rsp,
    output req_t     data_req,
    output logic     data_valid
);

    logic addr_phase;
    logic err_q;

    // Only NONSEQ opens a transfer, anything else counts as idle
    assign addr_phase = (req.htrans == NONSEQ);

    // --------------------
    // Address phase capture
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            data_valid <= addr_phase;
            if (addr_phase) begin
                err_q <= addr_err;
            end
        end
    end

    // Request fields carried into the data phase
    always_ff @(posedge clk) begin
        if (addr_phase) begin
            data_req <= req;
        end
    end

    // --------------------
    // Data phase response
    // --------------------
    always_comb begin
        rsp.hready = data_valid;
        rsp.hresp  = OKAY;
        rsp.hrdata = '0;
        if (data_valid) begin
            if (err_q) begin
                // Faulting access returns no data
                rsp.hresp = ERROR;
            end else begin
                rsp.hrdata = rdata;
            end
        end
    end

endmodule

//--- mem_array.sv
/*
 * Shared byte array behind both ports
 * Two registered read ports with write forwarding, one write port
 */

`timescale 1ns/1ps

`include "ahb_mem_config.svh"

module mem_array
    import ahb_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  imem_req_t imem_req,
    input  dmem_req_t dmem_req,
    input  logic      wr_en,
    input  word_t     wr_addr,
    input  be_t       wr_be,
    input  word_t     wr_data,
    output word_t     imem_rdata,
    output word_t     dmem_rdata
);

    localparam int IDX_W = `MEM_POWER_SIZE - 2;

    logic [7:0] mem [2**`MEM_POWER_SIZE];

    logic [IDX_W-1:0] wr_idx;

    // Addresses wrap on the array size
    assign wr_idx = wr_addr[`MEM_POWER_SIZE-1:2];

    // Enabled bytes of one word, newer data from the write port wins
    function automatic word_t read_word(word_t addr, be_t be);
        word_t            rd;
        logic [IDX_W-1:0] idx;
        be_t              fwd;
        idx = addr[`MEM_POWER_SIZE-1:2];
        fwd = (wr_en && (wr_idx == idx)) ? (be & wr_be) : 4'b0000;
        for (int i = 0; i < 4; i++) begin
            if (fwd[i]) begin
                rd[8*i +: 8] = wr_data[8*i +: 8];
            end else if (be[i]) begin
                rd[8*i +: 8] = mem[{idx, 2'(i)}];
            end else begin
                rd[8*i +: 8] = 8'h00;
            end
        end
        return rd;
    endfunction

    // --------------------
    // Read ports
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            imem_rdata <= '0;
            dmem_rdata <= '0;
        end else begin
            if (imem_req.htrans == NONSEQ) begin
                imem_rdata <= read_word(imem_req.haddr,
                                        be_form(imem_req.hsize, imem_req.haddr[1:0]));
            end
            // Writes have no read data to fetch
            if (dmem_req.htrans == NONSEQ && !dmem_req.hwrite) begin
                dmem_rdata <= read_word(dmem_req.haddr,
                                        be_form(dmem_req.hsize, dmem_req.haddr[1:0]));
            end
        end
    end

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i]) begin
                    mem[{wr_idx, 2'(i)}] <= wr_data[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- mmio_regs.sv
/*
 * Address decode and register block
 * Error detection, IRQ and error-pointer registers, data read mux
 */

`timescale 1ns/1ps

`include "ahb_mem_config.svh"

module mmio_regs
    import ahb_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  word_t                     imem_addr,
    input  dmem_req_t                 dmem_req,
    input  dmem_req_t                 data_req,
    input  logic                      data_valid,
    input  word_t                     hwdata,
    input  word_t                     mem_rdata,
    output logic                      imem_err,
    output logic                      dmem_err,
    output word_t                     dmem_rdata,
    output logic                      wr_en,
    output be_t                       wr_be,
    output logic [`IRQ_LINES_NUM-1:0] irq_lines
);

    typedef enum logic [1:0] {
        SEL_MEM,
        SEL_IRQ,
        SEL_PTR,
        SEL_ERR
    } sel_e;

    word_t                     err_ptr;
    logic [`IRQ_LINES_NUM-1:0] irq_reg;
    sel_e                      sel_d;
    sel_e                      sel_q;
    logic                      reg_wr;

    // --------------------
    // Address phase decode
    // --------------------
    assign imem_err = (imem_addr == `MEM_ERR_ADDR) || (imem_addr == err_ptr);
    assign dmem_err = (dmem_req.haddr == `MEM_ERR_ADDR) || (dmem_req.haddr == err_ptr);

    always_comb begin
        if (dmem_err) begin
            sel_d = SEL_ERR;
        end else if (dmem_req.haddr == `IRQ_ADDR) begin
            sel_d = SEL_IRQ;
        end else if (dmem_req.haddr == `ERR_PTR_ADDR) begin
            sel_d = SEL_PTR;
        end else begin
            sel_d = SEL_MEM;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= SEL_MEM;
        end else if (dmem_req.htrans == NONSEQ) begin
            sel_q <= sel_d;
        end
    end

    // --------------------
    // Data phase
    // --------------------
    assign reg_wr = data_valid && data_req.hwrite;
    // Faulting writes never reach the array
    assign wr_en  = reg_wr && (sel_q == SEL_MEM);
    assign wr_be  = be_form(data_req.hsize, data_req.haddr[1:0]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_reg <= '0;
            err_ptr <= `MEM_ERR_ADDR;
        end else if (reg_wr) begin
            if (sel_q == SEL_IRQ) begin
                irq_reg <= hwdata[`IRQ_LINES_NUM-1:0];
            end
            if (sel_q == SEL_PTR) begin
                err_ptr <= hwdata;
            end
        end
    end

    always_comb begin
        case (sel_q)
            SEL_IRQ: dmem_rdata = {{(`AHB_WIDTH-`IRQ_LINES_NUM){1'b0}}, irq_reg};
            SEL_PTR: dmem_rdata = err_ptr;
            default: dmem_rdata = mem_rdata;
        endcase
    end

    assign irq_lines = irq_reg;

endmodule

//--- ahb_dual_mem.sv
/*
 * Dual-port AHB-Lite memory top level
 * Instruction and data ports over one shared byte array
 */

`timescale 1ns/1ps

`include "ahb_mem_config.svh"

module ahb_dual_mem
    import ahb_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  imem_req_t                 imem_req,
    output ahb_rsp_t                  imem_rsp,
    input  dmem_req_t                 dmem_req,
    input  word_t                     dmem_hwdata,
    output ahb_rsp_t                  dmem_rsp,
    output logic [`IRQ_LINES_NUM-1:0] irq_lines
);

    word_t     imem_mem_rdata;
    word_t     dmem_mem_rdata;
    word_t     dmem_rdata;
    logic      imem_err;
    logic      dmem_err;
    logic      wr_en;
    be_t       wr_be;
    dmem_req_t dmem_data_req;
    logic      dmem_data_valid;

    // --------------------
    // Port pipelines
    // --------------------
    ahb_port_ctrl #(.req_t(imem_req_t)) u_imem_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (imem_req),
        .addr_err   (imem_err),
        .rdata      (imem_mem_rdata),
        .rsp        (imem_rsp),
        .data_req   (),
        .data_valid ()
    );

    ahb_port_ctrl #(.req_t(dmem_req_t)) u_dmem_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (dmem_req),
        .addr_err   (dmem_err),
        .rdata      (dmem_rdata),
        .rsp        (dmem_rsp),
        .data_req   (dmem_data_req),
        .data_valid (dmem_data_valid)
    );

    // --------------------
    // Storage and registers
    // --------------------
    mem_array u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .wr_en      (wr_en),
        .wr_addr    (dmem_data_req.haddr),
        .wr_be      (wr_be),
        .wr_data    (dmem_hwdata),
        .imem_rdata (imem_mem_rdata),
        .dmem_rdata (dmem_mem_rdata)
    );

    mmio_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_req.haddr),
        .dmem_req   (dmem_req),
        .data_req   (dmem_data_req),
        .data_valid (dmem_data_valid),
        .hwdata     (dmem_hwdata),
        .mem_rdata  (dmem_mem_rdata),
        .imem_err   (imem_err),
        .dmem_err   (dmem_err),
        .dmem_rdata (dmem_rdata),
        .wr_en      (wr_en),
        .wr_be      (wr_be),
        .irq_lines  (irq_lines)
    );

endmodule

//--- tb_clock_gen.sv
/*
 * Testbench clock and synchronous reset source
 */

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released on a rising edge so the DUT sees a clean first cycle
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb_ahb_dual_mem.sv
/*
 * Directed testbench for the dual-port AHB-Lite memory
 * Byte-array reference model, per-cycle response checks, cycle limit
 */

`timescale 1ns/1ps

`include "ahb_mem_config.svh"

module tb_ahb_dual_mem
    import ahb_mem_pkg::*;
();

    localparam int CYCLE_LIMIT = 3000;

    typedef enum {TGT_MEM, TGT_IRQ, TGT_PTR, TGT_DROP} target_e;

    logic                      clk;
    logic                      rst_n;
    imem_req_t                 imem_req;
    dmem_req_t                 dmem_req;
    word_t                     dmem_hwdata;
    ahb_rsp_t                  imem_rsp;
    ahb_rsp_t                  dmem_rsp;
    logic [`IRQ_LINES_NUM-1:0] irq_lines;

    // Reference model state
    logic [7:0]                model_mem [2**`MEM_POWER_SIZE];
    word_t                     model_ptr;
    logic [`IRQ_LINES_NUM-1:0] model_irq;

    // Write waiting for its data phase
    logic    pend_wr;
    target_e pend_tgt;
    word_t   pend_addr;
    hsize_e  pend_size;
    word_t   pend_data;

    // Responses due in the current data phase
    ahb_rsp_t exp_i;
    ahb_rsp_t exp_d;
    logic     exp_d_data;

    int seed;
    int cycle_count = 0;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ahb_dual_mem DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req    (imem_req),
        .imem_rsp    (imem_rsp),
        .dmem_req    (dmem_req),
        .dmem_hwdata (dmem_hwdata),
        .dmem_rsp    (dmem_rsp),
        .irq_lines   (irq_lines)
    );

    // --------------------
    // Reference model
    // --------------------
    // Lanes from the first touched byte, as many as the size covers
    function automatic be_t lanes(hsize_e size, logic [1:0] offset);
        be_t be;
        int  first;
        int  count;
        first = (size == WORD) ? 0 : int'(offset);
        count = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
        for (int i = 0; i < 4; i++) begin
            be[i] = (i >= first) && (i < first + count);
        end
        return be;
    endfunction

    function automatic int byte_index(word_t addr, int lane);
        return int'(addr[`MEM_POWER_SIZE-1:2]) * 4 + lane;
    endfunction

    function automatic word_t model_read(word_t addr, hsize_e size);
        word_t data;
        be_t   be;
        be = lanes(size, addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            data[8*i +: 8] = be[i] ? model_mem[byte_index(addr, i)] : 8'h00;
        end
        return data;
    endfunction

    function automatic logic is_error(word_t addr);
        return (addr == `MEM_ERR_ADDR) || (addr == model_ptr);
    endfunction

    function automatic target_e target_of(word_t addr, logic err);
        if (err) begin
            return TGT_DROP;
        end
        if (addr == `IRQ_ADDR) begin
            return TGT_IRQ;
        end
        if (addr == `ERR_PTR_ADDR) begin
            return TGT_PTR;
        end
        return TGT_MEM;
    endfunction

    task automatic commit_write();
        be_t be;
        be = lanes(pend_size, pend_addr[1:0]);
        case (pend_tgt)
            TGT_MEM: begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        model_mem[byte_index(pend_addr, i)] = pend_data[8*i +: 8];
                    end
                end
            end
            TGT_IRQ: model_irq = pend_data[`IRQ_LINES_NUM-1:0];
            TGT_PTR: model_ptr = pend_data;
            default: ;
        endcase
    endtask

    // --------------------
    // Checks
    // --------------------
    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic check_rsp(input string name, input ahb_rsp_t act, input ahb_rsp_t exp,
                             input logic with_data);
        if (act.hready !== exp.hready) begin
            $display("[ERROR] %0d ns %s.hready: got %b, expected %b",
                     $time, name, act.hready, exp.hready);
            abort_run();
        end
        if (act.hresp !== exp.hresp) begin
            $display("[ERROR] %0d ns %s.hresp: got %b, expected %b",
                     $time, name, act.hresp, exp.hresp);
            abort_run();
        end
        if (with_data) begin
            check_word({name, ".hrdata"}, act.hrdata, exp.hrdata);
        end
    endtask

    task automatic check_irq(input logic [`IRQ_LINES_NUM-1:0] act,
                             input logic [`IRQ_LINES_NUM-1:0] exp);
        if (act !== exp) begin
            $display("[ERROR] %0d ns irq_lines: got %h, expected %h", $time, act, exp);
            abort_run();
        end
    endtask

    // --------------------
    // Bus driver
    // --------------------
    // One clock: new address phases, data phase of the previous ones
    task automatic bus_cycle(input logic i_go, input word_t i_addr, input hsize_e i_size,
                             input logic d_go, input logic d_wr, input word_t d_addr,
                             input hsize_e d_size, input word_t d_wdata);
        logic                      i_err;
        logic                      d_err;
        logic [`IRQ_LINES_NUM-1:0] irq_now;
        ahb_rsp_t                  nxt_i;
        ahb_rsp_t                  nxt_d;
        @(posedge clk);
        imem_req.htrans <= i_go ? NONSEQ : IDLE;
        imem_req.hsize  <= i_size;
        imem_req.haddr  <= i_addr;
        dmem_req.htrans <= d_go ? NONSEQ : IDLE;
        dmem_req.hsize  <= d_size;
        dmem_req.haddr  <= d_addr;
        dmem_req.hwrite <= d_wr;
        dmem_hwdata     <= pend_wr ? pend_data : word_t'($random(seed));

        // Decode sees the pointer before the pending write lands
        i_err   = is_error(i_addr);
        d_err   = is_error(d_addr);
        irq_now = model_irq;
        if (pend_wr) begin
            commit_write();
        end
        nxt_i = '0;
        nxt_d = '0;
        if (i_go) begin
            nxt_i.hready = 1'b1;
            nxt_i.hresp  = i_err ? ERROR : OKAY;
            nxt_i.hrdata = i_err ? '0 : model_read(i_addr, i_size);
        end
        if (d_go) begin
            nxt_d.hready = 1'b1;
            nxt_d.hresp  = d_err ? ERROR : OKAY;
            case (target_of(d_addr, d_err))
                TGT_DROP: nxt_d.hrdata = '0;
                TGT_IRQ:  nxt_d.hrdata = word_t'(model_irq);
                TGT_PTR:  nxt_d.hrdata = model_ptr;
                default:  nxt_d.hrdata = model_read(d_addr, d_size);
            endcase
        end
        pend_wr   = d_go && d_wr;
        pend_tgt  = target_of(d_addr, d_err);
        pend_addr = d_addr;
        pend_size = d_size;
        pend_data = d_wdata;

        @(negedge clk);
        check_rsp("imem_rsp", imem_rsp, exp_i, 1'b1);
        check_rsp("dmem_rsp", dmem_rsp, exp_d, exp_d_data);
        check_irq(irq_lines, irq_now);
        exp_i      = nxt_i;
        exp_d      = nxt_d;
        // Read data of a write is only defined when it faults
        exp_d_data = !(d_go && d_wr) || d_err;
    endtask

    task automatic idle_cycle();
        bus_cycle(1'b0, '0, WORD, 1'b0, 1'b0, '0, WORD, '0);
    endtask

    task automatic write_data_port(input word_t addr, input hsize_e size, input word_t data);
        bus_cycle(1'b0, '0, WORD, 1'b1, 1'b1, addr, size, data);
    endtask

    task automatic read_data_port(input word_t addr, input hsize_e size);
        bus_cycle(1'b0, '0, WORD, 1'b1, 1'b0, addr, size, '0);
    endtask

    task automatic read_instr_port(input word_t addr, input hsize_e size);
        bus_cycle(1'b1, addr, size, 1'b0, 1'b0, '0, WORD, '0);
    endtask

    task automatic read_both_ports(input word_t addr, input hsize_e size);
        bus_cycle(1'b1, addr, size, 1'b1, 1'b0, addr, size, '0);
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset();
        idle_cycle();
        read_data_port(`ERR_PTR_ADDR, WORD);
        idle_cycle();
    endtask

    task automatic test_sizes();
        hsize_e size;
        word_t  base;
        int     n;
        n = 0;
        for (int s = 0; s < 3; s++) begin
            size = hsize_e'(s);
            for (int off = 0; off < 4; off += 1 << s) begin
                base = 32'h0000_0400 + word_t'(4 * n);
                n++;
                write_data_port(base, WORD, $random(seed));
                write_data_port(base + word_t'(off), size, $random(seed));
                read_both_ports(base + word_t'(off), size);
                read_both_ports(base, WORD);
            end
        end
        idle_cycle();
    endtask

    task automatic test_forwarding();
        word_t addr;
        addr = 32'h0000_0800;
        write_data_port(addr, WORD, $random(seed));
        read_instr_port(addr, WORD);
        write_data_port(addr + 2, HALF, $random(seed));
        read_data_port(addr, WORD);
        // Instruction read in the same cycle as a data write address
        bus_cycle(1'b1, addr, WORD, 1'b1, 1'b1, addr + 1, BYTE, $random(seed));
        read_both_ports(addr, WORD);
        // Back to back over the words of the size test
        for (int i = 0; i < 7; i++) begin
            bus_cycle(1'b1, 32'h0000_0400 + word_t'(4 * i), WORD,
                      1'b1, 1'b0, 32'h0000_0418 - word_t'(4 * i), WORD, '0);
        end
        idle_cycle();
    endtask

    task automatic test_errors();
        word_t victim;
        victim = 32'h0000_0A00;
        // Word that the fixed error address wraps onto
        write_data_port(32'h0000_0100, WORD, $random(seed));
        write_data_port(victim, WORD, $random(seed));
        read_both_ports(`MEM_ERR_ADDR, WORD);
        write_data_port(`MEM_ERR_ADDR, WORD, $random(seed));
        read_both_ports(32'h0000_0100, WORD);
        write_data_port(`ERR_PTR_ADDR, WORD, victim);
        idle_cycle();
        read_data_port(`ERR_PTR_ADDR, WORD);
        read_both_ports(victim, WORD);
        write_data_port(victim, WORD, $random(seed));
        write_data_port(`ERR_PTR_ADDR, WORD, `MEM_ERR_ADDR);
        idle_cycle();
        read_both_ports(victim, WORD);
        idle_cycle();
    endtask

    task automatic test_irq();
        write_data_port(`IRQ_ADDR, WORD, 32'hABCD_5A3C);
        idle_cycle();
        idle_cycle();
        read_data_port(`IRQ_ADDR, WORD);
        write_data_port(`IRQ_ADDR, WORD, 32'h0000_81E7);
        read_data_port(`IRQ_ADDR, WORD);
        idle_cycle();
        idle_cycle();
    endtask

    task automatic test_random();
        word_t written[$];
        word_t addr;
        int    k;
        for (int n = 0; n < 100; n++) begin
            // Upper bits vary so addresses also wrap
            addr = word_t'($random(seed)) & 32'h0FFF_FFFC;
            written.push_back(addr);
            write_data_port(addr, WORD, $random(seed));
        end
        for (int n = 0; n < 100; n++) begin
            k = $unsigned($random(seed)) % written.size();
            addr = written[k];
            k = $unsigned($random(seed)) % written.size();
            bus_cycle(1'b1, addr, WORD, 1'b1, 1'b0, written[k], WORD, '0);
        end
        idle_cycle();
    endtask

    // --------------------
    // Run control
    // --------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        seed        = 32'h6023_72e9;
        imem_req    = '0;
        dmem_req    = '0;
        dmem_hwdata = '0;
        model_ptr   = `MEM_ERR_ADDR;
        model_irq   = '0;
        pend_wr     = 1'b0;
        exp_i       = '0;
        exp_d       = '0;
        exp_d_data  = 1'b1;
        wait (rst_n === 1'b1);
        test_reset();
        test_sizes();
        test_forwarding();
        test_errors();
        test_irq();
        test_random();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
ahb_mem_pkg.sv
ahb_port_ctrl.sv
mem_array.sv
mmio_regs.sv
ahb_dual_mem.sv
tb_clock_gen.sv
tb_ahb_dual_mem.sv

//--- Makefile
# Verilator flow for the dual-port AHB-Lite memory testbench

TOP := tb_ahb_dual_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f build.f -o sim

# Pass only when the log holds the pass line
run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
